//--- project.f
source/pixel_pkg.sv
source/flow_pkg.sv
source/pixel_if.sv
source/pixel_ingress.sv
source/rgb_to_hsv.sv
source/pixel_egress.sv
source/hsv_convert_top.sv
tb/tb_hsv_convert.sv

//--- Makefile
# Verilator flow for the HSV converter
VERILATOR  ?= verilator
FILELIST   ?= project.f
TB_TOP     ?= tb_hsv_convert
RTL_TOP    ?= hsv_convert_top
OBJ_DIR    ?= obj_dir
SIM_BIN    ?= sim_hsv_convert
SIM_FLAGS  ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only -Wall --timing
PASS_TEXT  ?= Test OK

SOURCES := $(wildcard source/*.sv) $(wildcard tb/*.sv)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

$(OBJ_DIR)/$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		-Mdir $(OBJ_DIR) -o $(SIM_BIN)

sim: $(OBJ_DIR)/$(SIM_BIN)
	@out="$$(./$(OBJ_DIR)/$(SIM_BIN) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

//--- tb/tb_hsv_convert.sv
/*
 * Testbench for the streaming RGB to HSV converter
 * Credit-obeying sender and receiver, reference model and comparator
 */
module tb_hsv_convert;

    localparam int CW             = pixel_pkg::COMP_WIDTH;
    localparam int PW             = pixel_pkg::PIXEL_WIDTH;
    localparam int RESET_CYCLES   = 5;
    localparam logic [31:0] SEED  = 32'h8330;
    localparam int BP_PIXELS      = 2 * (flow_pkg::IN_DEPTH + flow_pkg::OUT_DEPTH);
    localparam int RANDOM_PIXELS  = 500;
    localparam int MIXED_PIXELS   = 200;
    localparam int SETTLE_CYCLES  = 4 * pixel_pkg::CONV_LATENCY;
    // Keeps the egress credit counter well below its 4-bit limit
    localparam int CREDIT_WINDOW  = 12;
    localparam int GRANT_NONE     = 0;
    localparam int GRANT_ALWAYS   = 1;
    localparam int GRANT_RANDOM   = 2;

    // Black, white, primaries, mixes and grey or tied levels
    localparam logic [PW-1:0] CORNER_RGB [20] = '{
        24'h000000, 24'hFFFFFF, 24'hFF0000, 24'h00FF00, 24'h0000FF,
        24'hFFFF00, 24'h00FFFF, 24'hFF00FF, 24'h808080, 24'h404040,
        24'h010101, 24'hFF8000, 24'h80FF00, 24'h0080FF, 24'h8000FF,
        24'hFF0080, 24'h7F7F00, 24'h00FEFE, 24'hFE00FE, 24'h102030
    };
    localparam int TOTAL_PIXELS   = BP_PIXELS + 20 + RANDOM_PIXELS + MIXED_PIXELS;
    localparam int TIMEOUT_CYCLES = 40 * TOTAL_PIXELS + 2000;

    logic          clk = 1'b0;
    logic          rst_n;
    logic          in_valid;
    logic [CW-1:0] in_r, in_g, in_b;
    logic          in_credit;
    logic          out_credit;
    logic          out_valid;
    logic [CW-1:0] out_h, out_s, out_v;

    // Pixels waiting for a sender credit, and expected results in order
    logic [PW-1:0] tx_q  [$];
    logic [PW-1:0] exp_q [$];

    int sent_cnt      = 0;
    int in_credit_cnt = 0;
    int grant_cnt     = 0;
    int rx_cnt        = 0;
    int cycle_cnt     = 0;
    int grant_mode    = GRANT_NONE;
    bit gaps          = 1'b0;

    hsv_convert_top i_hsv_convert_top (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_r       (in_r),
        .in_g       (in_g),
        .in_b       (in_b),
        .in_credit  (in_credit),
        .out_credit (out_credit),
        .out_valid  (out_valid),
        .out_h      (out_h),
        .out_s      (out_s),
        .out_v      (out_v)
    );

    always #4 clk = ~clk;

    // ==================================================
    // Reporting and reference model
    // ==================================================

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("Test FAILED");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic report_mismatch(input string field, input int got, input int exp);
        $display("Mismatch at %0t: %s got %0d, expected %0d", $time, field, got, exp);
        stop_with_error("Output pixel differs from the reference model");
    endtask

    // HSV by the conversion rules, tie priority R then G then B
    function automatic logic [PW-1:0] ref_hsv(input logic [CW-1:0] r, g, b);
        int ri, gi, bi, mx, mn, delta, diff, sector, hue, sat;
        ri = int'(r);
        gi = int'(g);
        bi = int'(b);
        mn = ri;
        if (gi < mn) mn = gi;
        if (bi < mn) mn = bi;
        if (ri >= gi && ri >= bi) begin
            mx = ri;
            diff = gi - bi;
            sector = 0;
        end else if (gi >= bi) begin
            mx = gi;
            diff = bi - ri;
            sector = 1;
        end else begin
            mx = bi;
            diff = ri - gi;
            sector = 2;
        end
        delta = mx - mn;
        sat = (mx == 0) ? 0 : (delta * 255) / mx;
        if (delta == 0) begin
            hue = 0;
        end else begin
            // Integer divide truncates toward zero
            hue = (diff * 255) / (6 * delta);
            if (sector == 0 && hue < 0) hue = hue + 255;
            else hue = hue + sector * int'(pixel_pkg::HUE_SECTOR);
        end
        return {hue[CW-1:0], sat[CW-1:0], mx[CW-1:0]};
    endfunction

    // ==================================================
    // Driving, one call per clock cycle
    // ==================================================

    task automatic tick();
        int            avail;
        logic [PW-1:0] px;
        @(posedge clk);
        #1;
        // Sender credits, initial IN_DEPTH plus returns minus sends
        avail = flow_pkg::IN_DEPTH + in_credit_cnt - sent_cnt;
        in_valid = 1'b0;
        if (tx_q.size() > 0 && avail > 0 && (!gaps || ($urandom() % 4) != 0)) begin
            px = tx_q.pop_front();
            {in_r, in_g, in_b} = px;
            in_valid = 1'b1;
            exp_q.push_back(ref_hsv(px[3*CW-1:2*CW], px[2*CW-1:CW], px[CW-1:0]));
            sent_cnt++;
        end
        out_credit = 1'b0;
        if (grant_mode != GRANT_NONE && (grant_cnt - rx_cnt) < CREDIT_WINDOW) begin
            if (grant_mode == GRANT_ALWAYS || ($urandom() % 2) == 0) begin
                out_credit = 1'b1;
                grant_cnt++;
            end
        end
    endtask

    task automatic drain();
        while (tx_q.size() > 0 || rx_cnt != sent_cnt) tick();
    endtask

    // ==================================================
    // Monitor and comparator, sampled mid-cycle
    // ==================================================

    always @(negedge clk) begin
        if (rst_n) begin
            if (in_credit) in_credit_cnt++;
            if (out_valid) begin
                rx_cnt++;
                assert (rx_cnt <= grant_cnt)
                    else stop_with_error("More output pixels than downstream credits granted");
                assert (exp_q.size() > 0)
                    else stop_with_error("Output pixel appeared with no pixel sent");
                check_pixel(exp_q.pop_front());
            end
        end
    end

    task automatic check_pixel(input logic [PW-1:0] exp);
        assert (out_h == exp[3*CW-1:2*CW])
            else report_mismatch("H", int'(out_h), int'(exp[3*CW-1:2*CW]));
        assert (out_s == exp[2*CW-1:CW])
            else report_mismatch("S", int'(out_s), int'(exp[2*CW-1:CW]));
        assert (out_v == exp[CW-1:0])
            else report_mismatch("V", int'(out_v), int'(exp[CW-1:0]));
    endtask

    // Run limit
    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            stop_with_error("Timeout, the run did not finish within the cycle limit");
        end
    end

    initial begin
        void'($urandom(SEED));
        rst_n      = 1'b0;
        in_valid   = 1'b0;
        in_r       = '0;
        in_g       = '0;
        in_b       = '0;
        out_credit = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rst_n = 1'b1;

        // Idle after reset, nothing may move
        repeat (20) tick();
        assert (in_credit_cnt == 0 && rx_cnt == 0)
            else stop_with_error("Credit or output activity after reset with no input");

        // No downstream credits, egress then ingress fill up
        repeat (BP_PIXELS) tx_q.push_back((PW)'($urandom()));
        while (in_credit_cnt < flow_pkg::OUT_DEPTH) tick();
        repeat (SETTLE_CYCLES) tick();
        assert (sent_cnt == flow_pkg::IN_DEPTH + flow_pkg::OUT_DEPTH)
            else stop_with_error("Sender credits not exhausted after ingress plus egress depth");
        assert (in_credit_cnt == flow_pkg::OUT_DEPTH)
            else stop_with_error("Credit returns under back-pressure differ from egress depth");
        assert (rx_cnt == 0)
            else stop_with_error("Output pixel sent without any downstream credit");
        grant_mode = GRANT_ALWAYS;
        drain();

        foreach (CORNER_RGB[i]) tx_q.push_back(CORNER_RGB[i]);
        drain();

        // Full-rate random stream
        repeat (RANDOM_PIXELS) tx_q.push_back((PW)'($urandom()));
        drain();

        // Random gaps on both sides
        gaps = 1'b1;
        grant_mode = GRANT_RANDOM;
        repeat (MIXED_PIXELS) tx_q.push_back((PW)'($urandom()));
        drain();

        if (rx_cnt == TOTAL_PIXELS && in_credit_cnt == sent_cnt) begin
            $display("Test OK");
            $finish;
        end else begin
            stop_with_error("Pixel or credit totals do not add up at the end of the run");
        end
    end

endmodule

//--- source/hsv_convert_top.sv
/*
 * Streaming RGB to HSV converter top
 * Ingress buffer, converter pipeline and egress FIFO
 */
module hsv_convert_top (
    input  logic                             clk,
    input  logic                             rst_n,
    // Upstream side, credit controlled
    input  logic                             in_valid,
    input  logic [pixel_pkg::COMP_WIDTH-1:0] in_r,
    input  logic [pixel_pkg::COMP_WIDTH-1:0] in_g,
    input  logic [pixel_pkg::COMP_WIDTH-1:0] in_b,
    output logic                             in_credit,
    // Downstream side, credit controlled
    input  logic                             out_credit,
    output logic                             out_valid,
    output logic [pixel_pkg::COMP_WIDTH-1:0] out_h,
    output logic [pixel_pkg::COMP_WIDTH-1:0] out_s,
    output logic [pixel_pkg::COMP_WIDTH-1:0] out_v
);

    // RGB into the converter, HSV out of it
    pixel_if ing_to_conv ();
    pixel_if conv_to_egr ();

    // Egress slot returned to the ingress reservation count
    logic slot_free;

    pixel_ingress i_pixel_ingress (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_r      (in_r),
        .in_g      (in_g),
        .in_b      (in_b),
        .in_credit (in_credit),
        .slot_free (slot_free),
        .issue     (ing_to_conv.source)
    );

    rgb_to_hsv i_rgb_to_hsv (
        .clk   (clk),
        .rst_n (rst_n),
        .rgb   (ing_to_conv.sink),
        .hsv   (conv_to_egr.source)
    );

    pixel_egress i_pixel_egress (
        .clk        (clk),
        .rst_n      (rst_n),
        .result     (conv_to_egr.sink),
        .out_credit (out_credit),
        .out_valid  (out_valid),
        .out_h      (out_h),
        .out_s      (out_s),
        .out_v      (out_v),
        .slot_free  (slot_free)
    );

endmodule

//--- source/pixel_egress.sv
/*
 * Pixel egress
 * Output FIFO, sends under downstream credits and returns
 * a slot reservation to ingress on every send
 */
module pixel_egress (
    input  logic                             clk,
    input  logic                             rst_n,
    pixel_if.sink                            result,
    input  logic                             out_credit,
    output logic                             out_valid,
    output logic [pixel_pkg::COMP_WIDTH-1:0] out_h,
    output logic [pixel_pkg::COMP_WIDTH-1:0] out_s,
    output logic [pixel_pkg::COMP_WIDTH-1:0] out_v,
    output logic                             slot_free
);

    // FIFO storage, packed {h, s, v}
    logic [pixel_pkg::PIXEL_WIDTH-1:0]  fifo_mem [flow_pkg::OUT_DEPTH];
    logic [pixel_pkg::PIXEL_WIDTH-1:0]  head;
    logic [flow_pkg::OUT_PTR_WIDTH-1:0] wr_ptr;
    logic [flow_pkg::OUT_PTR_WIDTH-1:0] rd_ptr;
    logic [flow_pkg::OUT_CNT_WIDTH-1:0] fill;
    logic                               fifo_full;

    // Credits granted by the receiver, none after reset
    logic [flow_pkg::CREDIT_WIDTH-1:0]  credits;
    logic                               do_send;

    assign fifo_full = (fill == (flow_pkg::OUT_CNT_WIDTH)'(flow_pkg::OUT_DEPTH));
    assign do_send   = (fill != '0) && (credits != '0);
    assign head      = fifo_mem[rd_ptr];

    // Send and slot return are the same event
    assign out_valid = do_send;
    assign slot_free = do_send;
    assign out_h     = head[3*pixel_pkg::COMP_WIDTH-1:2*pixel_pkg::COMP_WIDTH];
    assign out_s     = head[2*pixel_pkg::COMP_WIDTH-1:pixel_pkg::COMP_WIDTH];
    assign out_v     = head[pixel_pkg::COMP_WIDTH-1:0];

    always_ff @(posedge clk) begin
        if (result.valid) begin
            fifo_mem[wr_ptr] <= {result.c0, result.c1, result.c2};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            fill    <= '0;
            credits <= '0;
        end else begin
            if (result.valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_send) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({result.valid, do_send})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;
            endcase
            // One credit per grant, one spent per send
            case ({out_credit, do_send})
                2'b10:   credits <= credits + 1'b1;
                2'b01:   credits <= credits - 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    // Full FIFO means every reservation is used, so the pipeline is empty
    a_full_pipe_empty: assert property (@(posedge clk) disable iff (!rst_n)
        fifo_full |-> (!result.valid) [*pixel_pkg::CONV_LATENCY])
        else $error("egress write while FIFO full");

    // Receiver must not grant past the counter range
    a_credit_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        (credits == '1) |-> (!out_credit || do_send))
        else $error("egress credit counter overflow");

endmodule

//--- source/rgb_to_hsv.sv
/*
 * RGB to HSV converter
 * Six-stage pipeline, one pixel per cycle, never stalls
 */
module rgb_to_hsv (
    input  logic    clk,
    input  logic    rst_n,
    pixel_if.sink   rgb,
    pixel_if.source hsv
);

    // One valid bit per stage
    logic [pixel_pkg::CONV_LATENCY-1:0] valid_q;

    // Stage 1 registered input
    logic [pixel_pkg::COMP_WIDTH-1:0]   r1, g1, b1;
    // Stage 2 extremes
    logic [pixel_pkg::COMP_WIDTH-1:0]   max2, delta2, r2, g2, b2;
    logic                               max_is_r2, max_is_g2;
    // Stage 3 saturation and hue difference
    logic [pixel_pkg::COMP_WIDTH-1:0]   v3, s3, delta3;
    logic signed [pixel_pkg::COMP_WIDTH:0] diff3;
    logic                               max_is_r3, max_is_g3;
    // Stage 4 hue numerator and denominator
    logic [pixel_pkg::COMP_WIDTH-1:0]   v4, s4;
    logic signed [2*pixel_pkg::COMP_WIDTH:0] num4;
    logic [pixel_pkg::COMP_WIDTH+2:0]   den4;
    logic                               max_is_r4, max_is_g4;
    // Stage 5 raw hue
    logic [pixel_pkg::COMP_WIDTH-1:0]   v5, s5;
    logic signed [pixel_pkg::COMP_WIDTH:0] raw5;
    logic                               max_is_r5, max_is_g5;
    // Stage 6 output
    logic [pixel_pkg::COMP_WIDTH-1:0]   h6, s6, v6;

    // Combinational results between stages
    logic                               r_top_c, g_top_c;
    logic [pixel_pkg::COMP_WIDTH-1:0]   max_c, min_c;
    logic [2*pixel_pkg::COMP_WIDTH-1:0] sat_num_c, sat_quo_c;
    logic signed [pixel_pkg::COMP_WIDTH:0] diff_c;
    logic signed [2*pixel_pkg::COMP_WIDTH:0] hue_num_c, hue_quo_c;
    logic [pixel_pkg::COMP_WIDTH+2:0]   hue_den_c;
    logic [pixel_pkg::COMP_WIDTH:0]     hue_off_c;
    logic signed [pixel_pkg::COMP_WIDTH:0] hue_sum_c;

    // ==================================================
    // Stage logic
    // ==================================================

    always_comb begin
        // Max priority on ties is R, then G, then B
        r_top_c = (r1 >= g1) && (r1 >= b1);
        g_top_c = !r_top_c && (g1 >= b1);
        max_c   = r_top_c ? r1 : (g_top_c ? g1 : b1);
        if ((r1 <= g1) && (r1 <= b1)) begin
            min_c = r1;
        end else if (g1 <= b1) begin
            min_c = g1;
        end else begin
            min_c = b1;
        end

        // S is delta * 255 / max, or zero for black
        sat_num_c = {{pixel_pkg::COMP_WIDTH{1'b0}}, delta2}
                  * {{pixel_pkg::COMP_WIDTH{1'b0}}, pixel_pkg::COMP_MAX};
        sat_quo_c = (max2 == '0) ? '0 : sat_num_c / {{pixel_pkg::COMP_WIDTH{1'b0}}, max2};
        // Signed difference of the two non-max components
        if (max_is_r2) begin
            diff_c = $signed({1'b0, g2}) - $signed({1'b0, b2});
        end else if (max_is_g2) begin
            diff_c = $signed({1'b0, b2}) - $signed({1'b0, r2});
        end else begin
            diff_c = $signed({1'b0, r2}) - $signed({1'b0, g2});
        end

        // Numerator diff * 255 over denominator 4*delta + 2*delta
        hue_num_c = diff3 * $signed({1'b0, pixel_pkg::COMP_MAX});
        hue_den_c = {1'b0, delta3, 2'b00} + {2'b00, delta3, 1'b0};

        // Signed divide truncates toward zero and grey gives zero
        if (den4 == '0) begin
            hue_quo_c = '0;
        end else begin
            hue_quo_c = num4 / $signed({{(pixel_pkg::COMP_WIDTH-2){1'b0}}, den4});
        end

        // Sector offset where R wraps negative hue
        if (max_is_r5) begin
            hue_off_c = raw5[pixel_pkg::COMP_WIDTH] ? {1'b0, pixel_pkg::COMP_MAX} : '0;
        end else if (max_is_g5) begin
            hue_off_c = {1'b0, pixel_pkg::HUE_SECTOR};
        end else begin
            hue_off_c = {pixel_pkg::HUE_SECTOR, 1'b0};
        end
        hue_sum_c = raw5 + $signed(hue_off_c);
    end

    // ==================================================
    // Pipeline registers
    // ==================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else begin
            valid_q <= {valid_q[pixel_pkg::CONV_LATENCY-2:0], rgb.valid};
        end
    end

    always_ff @(posedge clk) begin
        if (rgb.valid) begin
            r1 <= rgb.c0;
            g1 <= rgb.c1;
            b1 <= rgb.c2;
        end
        // Delta uses this pixel's own extremes
        if (valid_q[0]) begin
            max2      <= max_c;
            delta2    <= max_c - min_c;
            max_is_r2 <= r_top_c;
            max_is_g2 <= g_top_c;
            {r2, g2, b2} <= {r1, g1, b1};
        end
        if (valid_q[1]) begin
            {v3, delta3, diff3} <= {max2, delta2, diff_c};
            s3 <= sat_quo_c[pixel_pkg::COMP_WIDTH-1:0];
            {max_is_r3, max_is_g3} <= {max_is_r2, max_is_g2};
        end
        if (valid_q[2]) begin
            {v4, s4, num4, den4} <= {v3, s3, hue_num_c, hue_den_c};
            {max_is_r4, max_is_g4} <= {max_is_r3, max_is_g3};
        end
        if (valid_q[3]) begin
            {v5, s5} <= {v4, s4};
            raw5 <= hue_quo_c[pixel_pkg::COMP_WIDTH:0];
            {max_is_r5, max_is_g5} <= {max_is_r4, max_is_g4};
        end
        // H keeps the low 8 bits
        if (valid_q[4]) begin
            h6 <= hue_sum_c[pixel_pkg::COMP_WIDTH-1:0];
            {s6, v6} <= {s5, v5};
        end
    end

    assign hsv.valid = valid_q[pixel_pkg::CONV_LATENCY-1];
    assign hsv.c0    = h6;
    assign hsv.c1    = s6;
    assign hsv.c2    = v6;

endmodule

//--- source/pixel_ingress.sv
/*
 * Pixel ingress
 * Credit-controlled input buffer, issues pixels only against
 * reserved egress slots so the converter never has to stall
 */
module pixel_ingress (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             in_valid,
    input  logic [pixel_pkg::COMP_WIDTH-1:0] in_r,
    input  logic [pixel_pkg::COMP_WIDTH-1:0] in_g,
    input  logic [pixel_pkg::COMP_WIDTH-1:0] in_b,
    output logic                             in_credit,
    input  logic                             slot_free,
    pixel_if.source                          issue
);

    // Circular buffer storage, packed {r, g, b}
    logic [pixel_pkg::PIXEL_WIDTH-1:0] buf_mem [flow_pkg::IN_DEPTH];
    logic [pixel_pkg::PIXEL_WIDTH-1:0] head;

    // Pointers wrap naturally, depth is a power of two
    logic [flow_pkg::IN_PTR_WIDTH-1:0] wr_ptr;
    logic [flow_pkg::IN_PTR_WIDTH-1:0] rd_ptr;
    logic [flow_pkg::IN_CNT_WIDTH-1:0] fill;

    // Free egress slots not yet claimed
    logic [flow_pkg::CREDIT_WIDTH-1:0] resv;
    logic                              do_issue;

    // Issue needs a pixel and a reserved slot
    assign do_issue = (fill != '0) && (resv != '0);
    assign head     = buf_mem[rd_ptr];

    // Each issue frees one entry, so one credit goes back
    assign in_credit   = do_issue;
    assign issue.valid = do_issue;
    assign issue.c0    = head[3*pixel_pkg::COMP_WIDTH-1:2*pixel_pkg::COMP_WIDTH];
    assign issue.c1    = head[2*pixel_pkg::COMP_WIDTH-1:pixel_pkg::COMP_WIDTH];
    assign issue.c2    = head[pixel_pkg::COMP_WIDTH-1:0];

    always_ff @(posedge clk) begin
        if (in_valid) begin
            buf_mem[wr_ptr] <= {in_r, in_g, in_b};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
            resv   <= (flow_pkg::CREDIT_WIDTH)'(flow_pkg::OUT_DEPTH);
        end else begin
            if (in_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_issue) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Occupancy, write and issue may coincide
            case ({in_valid, do_issue})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;
            endcase
            // Reservations, claimed by issue and returned by egress
            case ({slot_free, do_issue})
                2'b10:   resv <= resv + 1'b1;
                2'b01:   resv <= resv - 1'b1;
                default: resv <= resv;
            endcase
        end
    end

    // Upstream sender must hold a credit for every write
    a_no_write_when_full: assert property (@(posedge clk) disable iff (!rst_n)
        in_valid |-> (fill != (flow_pkg::IN_CNT_WIDTH)'(flow_pkg::IN_DEPTH)))
        else $error("ingress write while buffer full");

    // Egress returns no more slots than it has
    a_resv_bounded: assert property (@(posedge clk) disable iff (!rst_n)
        resv <= (flow_pkg::CREDIT_WIDTH)'(flow_pkg::OUT_DEPTH))
        else $error("ingress reservation count above egress depth");

endmodule

//--- source/pixel_if.sv
/*
 * Pixel link
 * Valid flag plus three colour components, no back-pressure
 */
interface pixel_if;

    // Sink takes the pixel in every cycle valid is high
    logic valid;

    // RGB or HSV depending on link position
    logic [pixel_pkg::COMP_WIDTH-1:0] c0;
    logic [pixel_pkg::COMP_WIDTH-1:0] c1;
    logic [pixel_pkg::COMP_WIDTH-1:0] c2;

    modport source (
        output valid, c0, c1, c2
    );

    modport sink (
        input valid, c0, c1, c2
    );

endinterface

//--- source/flow_pkg.sv
/*
 * Flow control definitions
 * Buffer depths, pointer and credit counter widths
 */
package flow_pkg;

    // Ingress buffer, also the sender's initial credit count
    localparam int IN_DEPTH = 4;
    localparam int IN_PTR_WIDTH = $clog2(IN_DEPTH);
    localparam int IN_CNT_WIDTH = $clog2(IN_DEPTH + 1);

    // Egress FIFO, also the initial ingress reservation count
    localparam int OUT_DEPTH = 8;
    localparam int OUT_PTR_WIDTH = $clog2(OUT_DEPTH);
    localparam int OUT_CNT_WIDTH = $clog2(OUT_DEPTH + 1);

    localparam int CREDIT_WIDTH = 4;

endpackage

//--- source/pixel_pkg.sv
/*
 * Pixel definitions
 * Component widths and colour constants for the HSV datapath
 */
package pixel_pkg;

    // Bits per colour component
    localparam int COMP_WIDTH = 8;

    // One packed RGB or HSV triple
    localparam int PIXEL_WIDTH = 3 * COMP_WIDTH;

    // Full-scale value, used as the S scale and the hue wrap
    localparam logic [COMP_WIDTH-1:0] COMP_MAX = {COMP_WIDTH{1'b1}};

    // Hue offset for one third of the circle
    localparam logic [COMP_WIDTH-1:0] HUE_SECTOR = (COMP_WIDTH)'(85);

    // Converter depth, input to output in cycles
    localparam int CONV_LATENCY = 6;

endpackage
